/* common/decode_cfg.svh */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction word width.
`define DEC_ILEN 32

// instruction memory geometry.
`define DEC_IMEM_AW 8
`define DEC_IMEM_DEPTH 256

// immediate width after sign extension.
`define DEC_XLEN 64

`endif

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

	// ####################
	// major opcodes, bits [6:0].
	typedef enum logic [6:0] {
		OPC_LOAD      = 7'b0000011,
		OPC_MISC_MEM  = 7'b0001111,
		OPC_OP_IMM    = 7'b0010011,
		OPC_AUIPC     = 7'b0010111,
		OPC_OP_IMM_32 = 7'b0011011,
		OPC_STORE     = 7'b0100011,
		OPC_OP        = 7'b0110011,
		OPC_LUI       = 7'b0110111,
		OPC_OP_32     = 7'b0111011,
		OPC_BRANCH    = 7'b1100011,
		OPC_JALR      = 7'b1100111,
		OPC_JAL       = 7'b1101111,
		OPC_SYSTEM    = 7'b1110011
	} opc_e;

	// instruction formats.
	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J,
		FMT_UNKNOWN
	} fmt_e;

	// ####################
	// mnemonics, rv64i base plus m extension.
	typedef enum logic [6:0] {
		OP_UNKNOWN,
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
		OP_SB, OP_SH, OP_SW, OP_SD,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
		OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK,
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW
	} op_e;

endpackage

/* common/decode_pkg.sv */
package decode_pkg;

	// instructions that need their own printing rule.
	typedef enum logic [1:0] {
		SP_NONE,
		SP_FENCE,
		SP_SYSTEM,
		SP_JALR
	} special_e;

	// attribute flags carried with every decoded record.
	typedef struct packed {
		logic     is_load;
		logic     is_mem;          // operand printed as offset(base).
		logic     is_unsigned;
		logic     is_arith_shift;
		special_e special;
	} dec_flags_t;

endpackage

/* design/imem.sv */
`include "decode_cfg.svh"

module imem (
	input  logic                    clk,
	input  logic                    load_en,
	input  logic [`DEC_IMEM_AW-1:0] load_addr,
	input  logic [`DEC_ILEN-1:0]    load_data,
	input  logic                    rd_en,
	input  logic [`DEC_IMEM_AW-1:0] rd_addr,
	output logic [`DEC_ILEN-1:0]    rd_data
);

	logic [`DEC_ILEN-1:0] mem [`DEC_IMEM_DEPTH];

	// read sees the old word when both ports hit the same address.
	always_ff @(posedge clk)
	begin
		if (load_en)
			mem[load_addr] <= load_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* design/imem_arbiter.sv */
`include "decode_cfg.svh"

module imem_arbiter (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [1:0]              req,
	input  logic [`DEC_IMEM_AW-1:0] addr [2],
	output logic [1:0]              gnt,
	output logic                    mem_en,
	output logic [`DEC_IMEM_AW-1:0] mem_addr
);

	// lane granted most recently.
	logic last;

	always_comb
	begin
		case (req)
			2'b01: gnt = 2'b01;
			2'b10: gnt = 2'b10;
			2'b11: gnt = last ? 2'b01 : 2'b10;
			default: gnt = 2'b00;
		endcase
	end

	assign mem_en   = |gnt;
	assign mem_addr = gnt[1] ? addr[1] : addr[0];

	// starts at 1 so lane 0 wins the first tie.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			last <= 1'b1;
		else if (|gnt)
			last <= gnt[1];
	end

endmodule

/* decoder/field_extract.sv */
`include "decode_cfg.svh"

module field_extract import rv_isa_pkg::*; (
	input  logic [`DEC_ILEN-1:0] instr,
	input  fmt_e                 fmt,
	output logic [4:0]           rd,
	output logic [4:0]           rs1,
	output logic [4:0]           rs2,
	output logic [`DEC_XLEN-1:0] imm
);

	localparam int XL = `DEC_XLEN;

	logic sign;

	assign sign = instr[31];

	// ####################
	// register fields, zero where the format has none.
	assign rd  = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? instr[11:7] : 5'd0;
	assign rs1 = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? instr[19:15] : 5'd0;
	assign rs2 = (fmt inside {FMT_R, FMT_S, FMT_B}) ? instr[24:20] : 5'd0;

	// ####################
	// immediates, always sign extended from bit 31.
	always_comb
	begin
		case (fmt)
			FMT_I:
				imm = {{(XL-12){sign}}, instr[31:20]};
			FMT_S:
				imm = {{(XL-12){sign}}, instr[31:25], instr[11:7]};
			FMT_B:
			begin
				imm = {{(XL-13){sign}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			FMT_U:
				imm = {{(XL-32){sign}}, instr[31:12], 12'd0};
			FMT_J:
			begin
				imm = {{(XL-21){sign}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default:
				imm = '0;
		endcase
	end

endmodule

/* decoder/instr_decode.sv */
`include "decode_cfg.svh"

module instr_decode import rv_isa_pkg::*, decode_pkg::*; (
	input  logic [`DEC_ILEN-1:0] instr,
	output op_e                  op,
	output fmt_e                 fmt,
	output dec_flags_t           flags,
	output logic [4:0]           rd,
	output logic [4:0]           rs1,
	output logic [4:0]           rs2,
	output logic [`DEC_XLEN-1:0] imm
);

	opc_e        opc;
	fmt_e        opc_fmt;
	logic [16:0] key;

	assign opc = opc_e'(instr[6:0]);
	assign key = {instr[31:25], instr[14:12], instr[6:0]};

	// ####################
	// mnemonic from funct7, funct3 and opcode.
	always_comb
	begin
		casez (key)
			{10'b??????????, OPC_LUI}:         op = OP_LUI;
			{10'b??????????, OPC_AUIPC}:       op = OP_AUIPC;
			{10'b??????????, OPC_JAL}:         op = OP_JAL;
			{7'b???????, 3'b000, OPC_JALR}:    op = OP_JALR;
			{7'b???????, 3'b000, OPC_BRANCH}:  op = OP_BEQ;
			{7'b???????, 3'b001, OPC_BRANCH}:  op = OP_BNE;
			{7'b???????, 3'b100, OPC_BRANCH}:  op = OP_BLT;
			{7'b???????, 3'b101, OPC_BRANCH}:  op = OP_BGE;
			{7'b???????, 3'b110, OPC_BRANCH}:  op = OP_BLTU;
			{7'b???????, 3'b111, OPC_BRANCH}:  op = OP_BGEU;
			{7'b???????, 3'b000, OPC_LOAD}:    op = OP_LB;
			{7'b???????, 3'b001, OPC_LOAD}:    op = OP_LH;
			{7'b???????, 3'b010, OPC_LOAD}:    op = OP_LW;
			{7'b???????, 3'b011, OPC_LOAD}:    op = OP_LD;
			{7'b???????, 3'b100, OPC_LOAD}:    op = OP_LBU;
			{7'b???????, 3'b101, OPC_LOAD}:    op = OP_LHU;
			{7'b???????, 3'b110, OPC_LOAD}:    op = OP_LWU;
			{7'b???????, 3'b000, OPC_STORE}:   op = OP_SB;
			{7'b???????, 3'b001, OPC_STORE}:   op = OP_SH;
			{7'b???????, 3'b010, OPC_STORE}:   op = OP_SW;
			{7'b???????, 3'b011, OPC_STORE}:   op = OP_SD;
			{7'b???????, 3'b000, OPC_OP_IMM}:  op = OP_ADDI;
			{7'b???????, 3'b010, OPC_OP_IMM}:  op = OP_SLTI;
			{7'b???????, 3'b011, OPC_OP_IMM}:  op = OP_SLTIU;
			{7'b???????, 3'b100, OPC_OP_IMM}:  op = OP_XORI;
			{7'b???????, 3'b110, OPC_OP_IMM}:  op = OP_ORI;
			{7'b???????, 3'b111, OPC_OP_IMM}:  op = OP_ANDI;
			// rv64 shifts take a 6-bit shamt, so funct7 bit 0 is free.
			{7'b000000?, 3'b001, OPC_OP_IMM}:  op = OP_SLLI;
			{7'b000000?, 3'b101, OPC_OP_IMM}:  op = OP_SRLI;
			{7'b010000?, 3'b101, OPC_OP_IMM}:  op = OP_SRAI;
			{7'b???????, 3'b000, OPC_OP_IMM_32}: op = OP_ADDIW;
			{7'b0000000, 3'b001, OPC_OP_IMM_32}: op = OP_SLLIW;
			{7'b0000000, 3'b101, OPC_OP_IMM_32}: op = OP_SRLIW;
			{7'b0100000, 3'b101, OPC_OP_IMM_32}: op = OP_SRAIW;
			{7'b0000000, 3'b000, OPC_OP}:      op = OP_ADD;
			{7'b0100000, 3'b000, OPC_OP}:      op = OP_SUB;
			{7'b0000000, 3'b001, OPC_OP}:      op = OP_SLL;
			{7'b0000000, 3'b010, OPC_OP}:      op = OP_SLT;
			{7'b0000000, 3'b011, OPC_OP}:      op = OP_SLTU;
			{7'b0000000, 3'b100, OPC_OP}:      op = OP_XOR;
			{7'b0000000, 3'b101, OPC_OP}:      op = OP_SRL;
			{7'b0100000, 3'b101, OPC_OP}:      op = OP_SRA;
			{7'b0000000, 3'b110, OPC_OP}:      op = OP_OR;
			{7'b0000000, 3'b111, OPC_OP}:      op = OP_AND;
			{7'b0000001, 3'b000, OPC_OP}:      op = OP_MUL;
			{7'b0000001, 3'b001, OPC_OP}:      op = OP_MULH;
			{7'b0000001, 3'b010, OPC_OP}:      op = OP_MULHSU;
			{7'b0000001, 3'b011, OPC_OP}:      op = OP_MULHU;
			{7'b0000001, 3'b100, OPC_OP}:      op = OP_DIV;
			{7'b0000001, 3'b101, OPC_OP}:      op = OP_DIVU;
			{7'b0000001, 3'b110, OPC_OP}:      op = OP_REM;
			{7'b0000001, 3'b111, OPC_OP}:      op = OP_REMU;
			{7'b0000000, 3'b000, OPC_OP_32}:   op = OP_ADDW;
			{7'b0100000, 3'b000, OPC_OP_32}:   op = OP_SUBW;
			{7'b0000000, 3'b001, OPC_OP_32}:   op = OP_SLLW;
			{7'b0000000, 3'b101, OPC_OP_32}:   op = OP_SRLW;
			{7'b0100000, 3'b101, OPC_OP_32}:   op = OP_SRAW;
			{7'b0000001, 3'b000, OPC_OP_32}:   op = OP_MULW;
			{7'b0000001, 3'b100, OPC_OP_32}:   op = OP_DIVW;
			{7'b0000001, 3'b101, OPC_OP_32}:   op = OP_DIVUW;
			{7'b0000001, 3'b110, OPC_OP_32}:   op = OP_REMW;
			{7'b0000001, 3'b111, OPC_OP_32}:   op = OP_REMUW;
			{7'b???????, 3'b000, OPC_MISC_MEM}: op = OP_FENCE;
			{7'b???????, 3'b001, OPC_MISC_MEM}: op = OP_FENCE_I;
			default:                           op = OP_UNKNOWN;
		endcase
		// ecall and ebreak differ only in imm bit 0, every other field is zero.
		if (opc == OPC_SYSTEM && instr[31:21] == '0 && instr[19:7] == '0)
			op = instr[20] ? OP_EBREAK : OP_ECALL;
	end

	// ####################
	// format follows the opcode.
	always_comb
	begin
		case (opc)
			OPC_OP, OPC_OP_32:            opc_fmt = FMT_R;
			OPC_STORE:                    opc_fmt = FMT_S;
			OPC_BRANCH:                   opc_fmt = FMT_B;
			OPC_LUI, OPC_AUIPC:           opc_fmt = FMT_U;
			OPC_JAL:                      opc_fmt = FMT_J;
			OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32,
			OPC_JALR, OPC_MISC_MEM, OPC_SYSTEM: opc_fmt = FMT_I;
			default:                      opc_fmt = FMT_UNKNOWN;
		endcase
	end

	assign fmt = (op == OP_UNKNOWN) ? FMT_UNKNOWN : opc_fmt;

	// flags, all zero for OP_UNKNOWN.
	always_comb
	begin
		flags.is_load = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
		flags.is_mem = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
			OP_SB, OP_SH, OP_SW, OP_SD};
		flags.is_unsigned = op inside {OP_BLTU, OP_BGEU, OP_LBU, OP_LHU, OP_LWU,
			OP_SLTIU, OP_SLTU, OP_MULHSU, OP_MULHU, OP_DIVU, OP_REMU,
			OP_DIVUW, OP_REMUW};
		flags.is_arith_shift = op inside {OP_SRAI, OP_SRA, OP_SRAIW, OP_SRAW};
		case (op)
			OP_FENCE, OP_FENCE_I: flags.special = SP_FENCE;
			OP_ECALL, OP_EBREAK:  flags.special = SP_SYSTEM;
			OP_JALR:              flags.special = SP_JALR;
			default:              flags.special = SP_NONE;
		endcase
	end

	field_extract field_extract_i (
		.instr (instr),
		.fmt   (fmt),
		.rd    (rd),
		.rs1   (rs1),
		.rs2   (rs2),
		.imm   (imm)
	);

endmodule

/* design/decode_lane.sv */
`include "decode_cfg.svh"

module decode_lane import rv_isa_pkg::*, decode_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic [`DEC_IMEM_AW-1:0] start_addr,
	input  logic [`DEC_IMEM_AW:0]   count,
	output logic                    rd_req,
	output logic [`DEC_IMEM_AW-1:0] rd_addr,
	input  logic                    rd_gnt,
	input  logic [`DEC_ILEN-1:0]    rd_data,
	output logic                    out_valid,
	output op_e                     out_op,
	output fmt_e                    out_fmt,
	output dec_flags_t              out_flags,
	output logic [4:0]              out_rd,
	output logic [4:0]              out_rs1,
	output logic [4:0]              out_rs2,
	output logic [`DEC_XLEN-1:0]    out_imm,
	output logic                    done,
	output logic                    busy
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT
	} state_e;

	state_e                  state;
	logic [`DEC_IMEM_AW-1:0] addr;
	logic [`DEC_IMEM_AW:0]   remaining;

	op_e                  dec_op;
	fmt_e                 dec_fmt;
	dec_flags_t           dec_flags;
	logic [4:0]           dec_rd;
	logic [4:0]           dec_rs1;
	logic [4:0]           dec_rs2;
	logic [`DEC_XLEN-1:0] dec_imm;

	assign rd_req  = (state == REQ);
	assign rd_addr = addr;
	// the done cycle still counts as busy.
	assign busy    = (state != IDLE) || done;

	// ####################
	// fetch sequencer.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= IDLE;
			addr      <= '0;
			remaining <= '0;
			out_valid <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			out_valid <= 1'b0;
			done      <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start && !busy && count != '0)
					begin
						state     <= REQ;
						addr      <= start_addr;
						remaining <= count;
					end
				end
				REQ:
				begin
					if (rd_gnt)
						state <= WAIT;
				end
				WAIT:
				begin
					// word is on rd_data now.
					out_valid <= 1'b1;
					addr      <= addr + 1'b1;
					remaining <= remaining - 1'b1;
					if (remaining == 1)
					begin
						done  <= 1'b1;
						state <= IDLE;
					end
					else
						state <= REQ;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// record register.
	always_ff @(posedge clk)
	begin
		if (state == WAIT)
		begin
			out_op    <= dec_op;
			out_fmt   <= dec_fmt;
			out_flags <= dec_flags;
			out_rd    <= dec_rd;
			out_rs1   <= dec_rs1;
			out_rs2   <= dec_rs2;
			out_imm   <= dec_imm;
		end
	end

	instr_decode instr_decode_i (
		.instr (rd_data),
		.op    (dec_op),
		.fmt   (dec_fmt),
		.flags (dec_flags),
		.rd    (dec_rd),
		.rs1   (dec_rs1),
		.rs2   (dec_rs2),
		.imm   (dec_imm)
	);

endmodule

/* design/decode_top.sv */
`include "decode_cfg.svh"

module decode_top import rv_isa_pkg::*, decode_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    load_en,
	input  logic [`DEC_IMEM_AW-1:0] load_addr,
	input  logic [`DEC_ILEN-1:0]    load_data,
	input  logic                    start [2],
	input  logic [`DEC_IMEM_AW-1:0] start_addr [2],
	input  logic [`DEC_IMEM_AW:0]   count [2],
	output logic                    out_valid [2],
	output op_e                     out_op [2],
	output fmt_e                    out_fmt [2],
	output dec_flags_t              out_flags [2],
	output logic [4:0]              out_rd [2],
	output logic [4:0]              out_rs1 [2],
	output logic [4:0]              out_rs2 [2],
	output logic [`DEC_XLEN-1:0]    out_imm [2],
	output logic                    done [2],
	output logic                    busy [2]
);

	logic [1:0]              rd_req;
	logic [1:0]              rd_gnt;
	logic [`DEC_IMEM_AW-1:0] rd_addr [2];
	logic                    mem_en;
	logic [`DEC_IMEM_AW-1:0] mem_addr;
	logic [`DEC_ILEN-1:0]    rd_data;

	imem imem_i (
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_en     (mem_en),
		.rd_addr   (mem_addr),
		.rd_data   (rd_data)
	);

	imem_arbiter imem_arbiter_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (rd_req),
		.addr     (rd_addr),
		.gnt      (rd_gnt),
		.mem_en   (mem_en),
		.mem_addr (mem_addr)
	);

	// ####################
	// both lanes see the same read data.
	for (genvar i = 0; i < 2; i++)
	begin : lane_g
		decode_lane decode_lane_i (
			.clk        (clk),
			.arst_n     (arst_n),
			.start      (start[i]),
			.start_addr (start_addr[i]),
			.count      (count[i]),
			.rd_req     (rd_req[i]),
			.rd_addr    (rd_addr[i]),
			.rd_gnt     (rd_gnt[i]),
			.rd_data    (rd_data),
			.out_valid  (out_valid[i]),
			.out_op     (out_op[i]),
			.out_fmt    (out_fmt[i]),
			.out_flags  (out_flags[i]),
			.out_rd     (out_rd[i]),
			.out_rs1    (out_rs1[i]),
			.out_rs2    (out_rs2[i]),
			.out_imm    (out_imm[i]),
			.done       (done[i]),
			.busy       (busy[i])
		);
	end

endmodule

/* test/tb_rv_encode.svh */
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

// one expected decoded record, fields in output order.
typedef struct packed {
	op_e             op;
	fmt_e            fmt;
	dec_flags_t      flags;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [63:0]     imm;
} rec_t;

// ####################
// instruction encoders.
function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, opc_e opc,
	logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, opc_e opc,
	logic [4:0] rd, logic [4:0] rs1);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [2:0] f3,
	logic [4:0] rs1, logic [4:0] rs2);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// imm bit 0 is dropped by the format.
function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3,
	logic [4:0] rs1, logic [4:0] rs2);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, opc_e opc, logic [4:0] rd);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// ####################
// expected record rules.
function automatic logic [63:0] sext(logic [63:0] v, int bits);
	logic signed [63:0] t;
	t = v << (64 - bits);
	return t >>> (64 - bits);
endfunction

function automatic dec_flags_t flags_for(op_e op);
	dec_flags_t f;
	f.is_load = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
	f.is_mem = f.is_load || (op inside {OP_SB, OP_SH, OP_SW, OP_SD});
	f.is_unsigned = op inside {OP_BLTU, OP_BGEU, OP_LBU, OP_LHU, OP_LWU, OP_SLTIU,
		OP_SLTU, OP_MULHSU, OP_MULHU, OP_DIVU, OP_REMU, OP_DIVUW, OP_REMUW};
	f.is_arith_shift = op inside {OP_SRAI, OP_SRA, OP_SRAIW, OP_SRAW};
	if (op inside {OP_FENCE, OP_FENCE_I})
		f.special = SP_FENCE;
	else if (op inside {OP_ECALL, OP_EBREAK})
		f.special = SP_SYSTEM;
	else if (op == OP_JALR)
		f.special = SP_JALR;
	else
		f.special = SP_NONE;
	return f;
endfunction

// register fields the format lacks read zero.
function automatic rec_t expect_rec(op_e op, fmt_e fmt, logic [4:0] rd, logic [4:0] rs1,
	logic [4:0] rs2, logic [63:0] imm);
	rec_t r;
	r.op    = op;
	r.fmt   = fmt;
	r.flags = flags_for(op);
	r.rd    = (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? rd : 5'd0;
	r.rs1   = (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? rs1 : 5'd0;
	r.rs2   = (fmt inside {FMT_R, FMT_S, FMT_B}) ? rs2 : 5'd0;
	r.imm   = (fmt inside {FMT_R, FMT_UNKNOWN}) ? 64'd0 : imm;
	return r;
endfunction

`endif

/* test/tb_decode_top.sv */
`include "decode_cfg.svh"

module tb_decode_top import rv_isa_pkg::*, decode_pkg::*;;

	`include "tb_rv_encode.svh"

	localparam int TIMEOUT = 1000;

	logic                    clk;
	logic                    arst_n;
	logic                    load_en;
	logic [`DEC_IMEM_AW-1:0] load_addr;
	logic [`DEC_ILEN-1:0]    load_data;
	logic                    start [2];
	logic [`DEC_IMEM_AW-1:0] start_addr [2];
	logic [`DEC_IMEM_AW:0]   count [2];
	logic                    out_valid [2];
	op_e                     out_op [2];
	fmt_e                    out_fmt [2];
	dec_flags_t              out_flags [2];
	logic [4:0]              out_rd [2];
	logic [4:0]              out_rs1 [2];
	logic [4:0]              out_rs2 [2];
	logic [`DEC_XLEN-1:0]    out_imm [2];
	logic                    done [2];
	logic                    busy [2];

	logic [31:0] prog [256];
	rec_t        exp_mem [256];
	rec_t        exp_q [2][$];
	int          wa;
	int          left [2];
	int          last_cyc [2];
	int          other_cnt [2];
	bit          first [2];
	bit          done_seen [2];
	bit          idle_chk;
	bit          lone_chk;
	bit          dual_chk;
	int          cyc;
	int          errors;
	int          checks;
	int          tests;

	decode_top decode_top_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// ####################
	// program building.
	function automatic logic [4:0] rreg();
		return 5'($urandom);
	endfunction

	task automatic put(op_e op, fmt_e fmt, logic [31:0] w, logic [4:0] rd, logic [4:0] rs1,
		logic [4:0] rs2, logic [63:0] imm);
		prog[wa]    = w;
		exp_mem[wa] = expect_rec(op, fmt, rd, rs1, rs2, imm);
		wa++;
	endtask

	task automatic build_mnemonics();
		op_e ld_op [7] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
		op_e st_op [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
		op_e br_op [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
		logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		op_e ii_op [6] = '{OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI};
		logic [2:0] ii_f3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
		op_e sh_op [6] = '{OP_SLLI, OP_SRLI, OP_SRAI, OP_SLLIW, OP_SRLIW, OP_SRAIW};
		logic [2:0] sh_f3 [6] = '{3'd1, 3'd5, 3'd5, 3'd1, 3'd5, 3'd5};
		logic [6:0] sh_f7 [6] = '{7'h00, 7'h00, 7'h20, 7'h00, 7'h00, 7'h20};
		op_e rr_op [10] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL,
			OP_SRA, OP_OR, OP_AND};
		logic [2:0] rr_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic [6:0] rr_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
			7'h00, 7'h00};
		op_e md_op [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU, OP_REM,
			OP_REMU};
		op_e rw_op [10] = '{OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW, OP_MULW, OP_DIVW,
			OP_DIVUW, OP_REMW, OP_REMUW};
		logic [2:0] rw_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd5, 3'd5, 3'd0, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [6:0] rw_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h20, 7'h01, 7'h01, 7'h01,
			7'h01, 7'h01};
		logic [11:0] imm;
		logic [11:0] shi;
		logic [19:0] u20;
		logic [20:0] j21;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		for (int i = 0; i < 44; i++)
		begin
			rd  = rreg();
			rs1 = rreg();
			rs2 = rreg();
			imm = 12'($urandom);
			if (i < 7)
				put(ld_op[i], FMT_I, enc_i(imm, 3'(i), OPC_LOAD, rd, rs1), rd, rs1, rs2,
					sext(imm, 12));
			else if (i < 11)
				put(st_op[i-7], FMT_S, enc_s(imm, 3'(i-7), rs1, rs2), rd, rs1, rs2,
					sext(imm, 12));
			else if (i < 17)
				put(br_op[i-11], FMT_B, enc_b({imm, 1'b0}, br_f3[i-11], rs1, rs2), rd, rs1,
					rs2, sext({imm, 1'b0}, 13));
			else if (i < 23)
				put(ii_op[i-17], FMT_I, enc_i(imm, ii_f3[i-17], OPC_OP_IMM, rd, rs1), rd, rs1,
					rs2, sext(imm, 12));
			else if (i < 26)
			begin
				// rv64 shamt is 6 bits wide.
				shi = {sh_f7[i-23][6:1], imm[5:0]};
				put(sh_op[i-23], FMT_I, enc_i(shi, sh_f3[i-23], OPC_OP_IMM, rd, rs1), rd,
					rs1, rs2, sext(shi, 12));
			end
			else if (i < 29)
			begin
				shi = {sh_f7[i-23], imm[4:0]};
				put(sh_op[i-23], FMT_I, enc_i(shi, sh_f3[i-23], OPC_OP_IMM_32, rd, rs1), rd,
					rs1, rs2, sext(shi, 12));
			end
			else if (i < 39)
				put(rr_op[i-29], FMT_R, enc_r(rr_f7[i-29], rr_f3[i-29], OPC_OP, rd, rs1, rs2),
					rd, rs1, rs2, 64'd0);
			else
				put(md_op[i-39], FMT_R, enc_r(7'h01, 3'(i-39), OPC_OP, rd, rs1, rs2), rd,
					rs1, rs2, 64'd0);
		end
		for (int i = 0; i < 13; i++)
		begin
			rd  = rreg();
			rs1 = rreg();
			rs2 = rreg();
			imm = 12'($urandom);
			if (i < 3)
				put(md_op[i+5], FMT_R, enc_r(7'h01, 3'(i+5), OPC_OP, rd, rs1, rs2), rd, rs1,
					rs2, 64'd0);
			else
				put(rw_op[i-3], FMT_R, enc_r(rw_f7[i-3], rw_f3[i-3], OPC_OP_32, rd, rs1, rs2),
					rd, rs1, rs2, 64'd0);
		end
		rd  = rreg();
		rs1 = rreg();
		imm = 12'($urandom);
		u20 = 20'($urandom);
		j21 = {20'($urandom), 1'b0};
		put(OP_ADDIW, FMT_I, enc_i(imm, 3'd0, OPC_OP_IMM_32, rd, rs1), rd, rs1, 0, sext(imm, 12));
		put(OP_LUI, FMT_U, enc_u(u20, OPC_LUI, rd), rd, 0, 0, sext({u20, 12'h0}, 32));
		put(OP_AUIPC, FMT_U, enc_u(~u20, OPC_AUIPC, rs1), rs1, 0, 0, sext({~u20, 12'h0}, 32));
		put(OP_JAL, FMT_J, enc_j(j21, rd), rd, 0, 0, sext(j21, 21));
		put(OP_JALR, FMT_I, enc_i(imm, 3'd0, OPC_JALR, rd, rs1), rd, rs1, 0, sext(imm, 12));
		put(OP_FENCE, FMT_I, enc_i(~imm, 3'd0, OPC_MISC_MEM, rd, rs1), rd, rs1, 0,
			sext(~imm, 12));
		put(OP_FENCE_I, FMT_I, enc_i(12'd0, 3'd1, OPC_MISC_MEM, 0, 0), 0, 0, 0, 64'd0);
		put(OP_ECALL, FMT_I, enc_i(12'd0, 3'd0, OPC_SYSTEM, 0, 0), 0, 0, 0, 64'd0);
		put(OP_EBREAK, FMT_I, enc_i(12'd1, 3'd0, OPC_SYSTEM, 0, 0), 0, 0, 0, 64'd1);
	endtask

	// edge immediates for every format.
	task automatic build_immediates();
		logic [11:0] iv [4] = '{12'h800, 12'h7ff, 12'hfff, 12'h001};
		logic [12:0] bv [3] = '{13'h1000, 13'h0ffe, 13'h1ffe};
		logic [19:0] uv [3] = '{20'h80000, 20'hfffff, 20'h7ffff};
		logic [20:0] jv [3] = '{21'h100000, 21'h0ffffe, 21'h1ffffe};
		for (int i = 0; i < 4; i++)
		begin
			put(OP_ADDI, FMT_I, enc_i(iv[i], 3'd0, OPC_OP_IMM, 5'd3, 5'd4), 3, 4, 0,
				sext(iv[i], 12));
			put(OP_SW, FMT_S, enc_s(iv[i], 3'd2, 5'd5, 5'd6), 0, 5, 6, sext(iv[i], 12));
		end
		for (int i = 0; i < 3; i++)
		begin
			put(OP_BNE, FMT_B, enc_b(bv[i], 3'd1, 5'd7, 5'd8), 0, 7, 8, sext(bv[i], 13));
			put(OP_LUI, FMT_U, enc_u(uv[i], OPC_LUI, 5'd9), 9, 0, 0, sext({uv[i], 12'h0}, 32));
			put(OP_JAL, FMT_J, enc_j(jv[i], 5'd1), 1, 0, 0, sext(jv[i], 21));
		end
	endtask

	task automatic build_unknown();
		logic [31:0] uw [8];
		uw = '{32'h0000_0000, 32'hffff_ffff, enc_r(7'h7f, 3'd0, OPC_OP, 1, 2, 3),
			enc_i(12'd5, 3'd7, OPC_LOAD, 1, 2), enc_b(13'd8, 3'd2, 1, 2),
			enc_i(12'd0, 3'd0, OPC_SYSTEM, 1, 0), enc_i(12'h401, 3'd1, OPC_OP_IMM, 1, 2),
			enc_r(7'h20, 3'd1, OPC_OP_32, 1, 2, 3)};
		for (int i = 0; i < 8; i++)
			put(OP_UNKNOWN, FMT_UNKNOWN, uw[i], 0, 0, 0, 64'd0);
	endtask

	// ####################
	// stimulus helpers.
	task automatic load_program();
		for (int a = 0; a < wa; a++)
		begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= a[`DEC_IMEM_AW-1:0];
			load_data <= prog[a];
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic expect_run(int l, int a, int c);
		for (int i = 0; i < c; i++)
			exp_q[l].push_back(exp_mem[a+i]);
		left[l]      = c;
		first[l]     = 1'b1;
		done_seen[l] = 1'b0;
		other_cnt[l] = 0;
	endtask

	task automatic pulse_start(int l, int a, int c);
		@(posedge clk);
		start[l]      <= 1'b1;
		start_addr[l] <= a[`DEC_IMEM_AW-1:0];
		count[l]      <= c[`DEC_IMEM_AW:0];
		@(posedge clk);
		start[l] <= 1'b0;
	endtask

	task automatic wait_done(int l);
		int n;
		n = 0;
		while (!done_seen[l] && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (!done_seen[l])
		begin
			errors++;
			$display("TIMEOUT: lane %0d stalled, no done within %0d cycles", l, TIMEOUT);
			$display("FAIL: see errors above");
			$finish;
		end
		else if (exp_q[l].size() != 0)
		begin
			errors++;
			$display("lane %0d finished with %0d records still missing", l, exp_q[l].size());
		end
	endtask

	task automatic report(string name, int err_before);
		tests++;
		$display("test %0s: %0s", name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	// ####################
	// record checker.
	task automatic check_lane(int l);
		rec_t got;
		rec_t exp;
		got = {out_op[l], out_fmt[l], out_flags[l], out_rd[l], out_rs1[l], out_rs2[l],
			out_imm[l]};
		if (idle_chk)
		begin
			checks++;
			assert (!out_valid[l] && !done[l] && !busy[l])
			else
			begin
				errors++;
				$display("CHECK FAILED %0t: lane %0d active while idle", $time, l);
			end
		end
		if (out_valid[l] && exp_q[l].size() == 0)
		begin
			errors++;
			$display("lane %0d produced a record nobody asked for at %0t", l, $time);
		end
		else if (out_valid[l])
		begin
			exp = exp_q[l].pop_front();
			left[l]--;
			checks += 3;
			assert (got == exp)
			else
			begin
				errors++;
				$display("CHECK FAILED %0t: lane %0d got %0s/%0s %h, expected %0s/%0s %h",
					$time, l, got.op.name(), got.fmt.name(), got, exp.op.name(),
					exp.fmt.name(), exp);
			end
			assert (done[l] == (left[l] == 0))
			else
			begin
				errors++;
				$display("CHECK FAILED %0t: lane %0d done is %0b with %0d left", $time, l,
					done[l], left[l]);
			end
			assert (busy[l])
			else
			begin
				errors++;
				$display("CHECK FAILED %0t: lane %0d busy low during a record", $time, l);
			end
			// the next request goes out with the record, so a lone lane is granted
			// every other cycle.
			if (lone_chk && !first[l])
			begin
				checks++;
				assert (cyc - last_cyc[l] == 2)
				else
				begin
					errors++;
					$display("CHECK FAILED %0t: lane %0d records %0d cycles apart", $time, l,
						cyc - last_cyc[l]);
				end
			end
			if (dual_chk && !first[l])
			begin
				checks++;
				assert (other_cnt[l] <= 1)
				else
				begin
					errors++;
					$display("CHECK FAILED %0t: lane %0d starved, %0d other records", $time, l,
						other_cnt[l]);
				end
			end
			if (done[l])
				done_seen[l] = 1'b1;
			first[l]       = 1'b0;
			last_cyc[l]    = cyc;
			other_cnt[l]   = 0;
			other_cnt[1-l] = other_cnt[1-l] + 1;
		end
		else if (done[l])
		begin
			errors++;
			$display("lane %0d pulsed done without a record at %0t", l, $time);
		end
	endtask

	always @(negedge clk)
	begin
		if (arst_n)
		begin
			check_lane(0);
			check_lane(1);
		end
	end

	// ####################
	// test sequence.
	initial
	begin
		int e;
		int imm_lo;
		int unk_lo;
		clk       = 1'b0;
		arst_n    = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int l = 0; l < 2; l++)
		begin
			start[l]      = 1'b0;
			start_addr[l] = '0;
			count[l]      = '0;
		end
		void'($urandom(32'ha820d76e));
		wa = 0;
		build_mnemonics();
		imm_lo = wa;
		build_immediates();
		unk_lo = wa;
		build_unknown();
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		e = errors;
		idle_chk = 1'b1;
		repeat (20) @(posedge clk);
		idle_chk = 1'b0;
		report("idle after reset", e);

		load_program();
		lone_chk = 1'b1;
		e = errors;
		expect_run(0, 0, imm_lo);
		pulse_start(0, 0, imm_lo);
		wait_done(0);
		report("mnemonics and registers", e);

		e = errors;
		expect_run(1, imm_lo, unk_lo - imm_lo);
		pulse_start(1, imm_lo, unk_lo - imm_lo);
		wait_done(1);
		report("immediates", e);

		e = errors;
		expect_run(0, unk_lo, wa - unk_lo);
		pulse_start(0, unk_lo, wa - unk_lo);
		wait_done(0);
		report("undefined words", e);
		lone_chk = 1'b0;

		e = errors;
		expect_run(0, 0, 40);
		expect_run(1, imm_lo, wa - imm_lo);
		dual_chk = 1'b1;
		@(posedge clk);
		start[0]      <= 1'b1;
		start[1]      <= 1'b1;
		start_addr[0] <= '0;
		start_addr[1] <= imm_lo[`DEC_IMEM_AW-1:0];
		count[0]      <= 40;
		count[1]      <= (wa - imm_lo);
		@(posedge clk);
		start[0] <= 1'b0;
		start[1] <= 1'b0;
		wait_done(0);
		wait_done(1);
		dual_chk = 1'b0;
		report("two lanes together", e);

		// the second start lands while the lane is busy.
		e = errors;
		lone_chk = 1'b1;
		expect_run(1, 0, 5);
		pulse_start(1, 0, 5);
		repeat (2) @(posedge clk);
		pulse_start(1, 50, 3);
		wait_done(1);
		lone_chk = 1'b0;
		pulse_start(0, 0, 0);
		idle_chk = 1'b1;
		repeat (20) @(posedge clk);
		idle_chk = 1'b0;
		report("busy start and zero count", e);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+common
+incdir+test
common/rv_isa_pkg.sv
common/decode_pkg.sv
design/imem.sv
design/imem_arbiter.sv
decoder/field_extract.sv
decoder/instr_decode.sv
design/decode_lane.sv
design/decode_top.sv
test/tb_decode_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
